//--- logic/board_ctrl_cfg.svh
`ifndef BOARD_CTRL_CFG_SVH
`define BOARD_CTRL_CFG_SVH

// register bus.
`define CSR_ADDR_W 5
`define CSR_DATA_W 8

`define CE_TICK_DIV 16         // clk cycles per slow tick.
`define LONG_PRESS_TICKS 3     // ticks held while on to force off.
`define WDT_DEFAULT_TIMEOUT 4  // watchdog reload value after reset.
`define GPIO_COUNT 8

// register map.
`define ADDR_WDT_CTRL 5'h04
`define ADDR_WDT_TIMEOUT 5'h05
`define ADDR_WDT_KICK 5'h06
`define ADDR_PWR_CTRL 5'h08
`define ADDR_GPIO_OUT 5'h10
`define ADDR_GPIO_OE 5'h11
`define ADDR_GPIO_IN 5'h12
`define ADDR_GPIO_IRQ_EN 5'h13
`define ADDR_IRQ_PENDING 5'h1c
`define ADDR_IRQ_ENABLE 5'h1d

`endif

//--- logic/board_ctrl_pkg.sv
`include "board_ctrl_cfg.svh"

package board_ctrl_pkg;

	// one bus request, valid in the cycle it is presented.
	typedef struct packed {
		logic [`CSR_ADDR_W-1:0] addr;
		logic we;
		logic [`CSR_DATA_W-1:0] wdata;
	} csr_req_t;

	typedef enum logic [`CSR_ADDR_W-1:0] {
		WDT_CTRL = `ADDR_WDT_CTRL,
		WDT_TIMEOUT = `ADDR_WDT_TIMEOUT,
		WDT_KICK = `ADDR_WDT_KICK,
		PWR_CTRL = `ADDR_PWR_CTRL,
		GPIO_OUT = `ADDR_GPIO_OUT,
		GPIO_OE = `ADDR_GPIO_OE,
		GPIO_IN = `ADDR_GPIO_IN,
		GPIO_IRQ_EN = `ADDR_GPIO_IRQ_EN,
		IRQ_PENDING = `ADDR_IRQ_PENDING,
		IRQ_ENABLE = `ADDR_IRQ_ENABLE
	} csr_addr_e;

	// one-cycle event pulses into the interrupt controller.
	typedef struct packed {
		logic wdt;
		logic gpio;
		logic pwr_btn;
		logic wake;
	} irq_src_t;

	typedef enum logic [1:0] {
		PWR_OFF = 2'd0,
		PWR_ON = 2'd1,
		PWR_HELD = 2'd2,
		PWR_WAIT_RELEASE = 2'd3
	} pwr_state_e;

endpackage

//--- logic/tick_gen.sv
`include "board_ctrl_cfg.svh"

module tick_gen (
	input  logic clk,
	input  logic rst,
	output logic ce_tick
);

	localparam int CNT_W = $clog2(`CE_TICK_DIV);

	logic [CNT_W-1:0] cnt;

	// ****************************************
	// slow clock enable
	// ****************************************

	// stands in for the 1 Hz enable of the board.
	always_ff @(posedge clk) begin
		if (rst) begin
			cnt <= '0;
			ce_tick <= 1'b0;
		end else if (cnt == CNT_W'(`CE_TICK_DIV - 1)) begin
			cnt <= '0;
			ce_tick <= 1'b1;  // one cycle per wrap.
		end else begin
			cnt <= cnt + 1'b1;
			ce_tick <= 1'b0;
		end
	end

endmodule

//--- logic/power_seq.sv
`include "board_ctrl_cfg.svh"

module power_seq import board_ctrl_pkg::*; (
	input  logic clk,
	input  logic rst,
	input  logic ce_tick,
	input  logic pwr_btn_n,
	input  logic wake_n,
	input  csr_req_t csr_req,
	output logic [`CSR_DATA_W-1:0] csr_rdata,
	output logic pwr_enable,
	output logic pwr_btn_evt,
	output logic wake_evt
);

	localparam int HELD_W = $clog2(`LONG_PRESS_TICKS + 1);

	pwr_state_e state;
	logic [1:0] btn_sync;   // button, active high.
	logic [1:0] wake_sync;  // wake, still active low.
	logic btn_d;
	logic wake_d;
	logic [HELD_W-1:0] held_cnt;
	logic btn_press;
	logic wake_fall;
	logic off_by_reg;

	assign btn_press = btn_sync[1] & ~btn_d;
	assign wake_fall = wake_d & ~wake_sync[1];
	assign off_by_reg = csr_req.we && csr_req.addr == PWR_CTRL && csr_req.wdata[0];
	assign pwr_enable = (state == PWR_ON) || (state == PWR_HELD);

	// ****************************************
	// input synchronisers
	// ****************************************

	always_ff @(posedge clk) begin
		if (rst) begin
			btn_sync <= 2'b00;
			wake_sync <= 2'b11;
			btn_d <= 1'b0;
			wake_d <= 1'b1;
			pwr_btn_evt <= 1'b0;
			wake_evt <= 1'b0;
		end else begin
			btn_sync <= {btn_sync[0], ~pwr_btn_n};
			wake_sync <= {wake_sync[0], wake_n};
			btn_d <= btn_sync[1];
			wake_d <= wake_sync[1];
			pwr_btn_evt <= btn_press;
			wake_evt <= wake_fall;
		end
	end

	// ****************************************
	// power state machine
	// ****************************************

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= PWR_OFF;
			held_cnt <= '0;
		end else if (off_by_reg) begin
			state <= PWR_OFF;
		end else begin
			case (state)
			PWR_OFF: begin
				if (btn_press || wake_fall)
					state <= PWR_ON;
			end
			PWR_ON: begin
				if (btn_sync[1]) begin
					state <= PWR_HELD;
					held_cnt <= '0;
				end
			end
			PWR_HELD: begin
				if (!btn_sync[1]) begin
					state <= PWR_ON;  // short press, stay on.
				end else if (ce_tick) begin
					if (held_cnt == HELD_W'(`LONG_PRESS_TICKS - 1))
						state <= PWR_WAIT_RELEASE;
					else
						held_cnt <= held_cnt + 1'b1;
				end
			end
			PWR_WAIT_RELEASE: begin
				if (!btn_sync[1])
					state <= PWR_OFF;
			end
			default: state <= PWR_OFF;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (rst)
			csr_rdata <= '0;
		else if (!csr_req.we && csr_req.addr == PWR_CTRL)
			csr_rdata <= {{(`CSR_DATA_W - 2){1'b0}}, btn_sync[1], pwr_enable};
		else
			csr_rdata <= '0;
	end

endmodule

//--- logic/watchdog.sv
`include "board_ctrl_cfg.svh"

module watchdog import board_ctrl_pkg::*; (
	input  logic clk,
	input  logic rst,
	input  logic ce_tick,
	input  logic pwr_enable,
	input  csr_req_t csr_req,
	output logic [`CSR_DATA_W-1:0] csr_rdata,
	output logic wdt_time_out,
	output logic wdt_evt
);

	logic wdt_en;
	logic [`CSR_DATA_W-1:0] timeout;
	logic [`CSR_DATA_W-1:0] count;
	logic wr_ctrl;
	logic wr_timeout;
	logic wr_kick;

	assign wr_ctrl = csr_req.we && csr_req.addr == WDT_CTRL;
	assign wr_timeout = csr_req.we && csr_req.addr == WDT_TIMEOUT;
	assign wr_kick = csr_req.we && csr_req.addr == WDT_KICK;

	// ****************************************
	// countdown
	// ****************************************

	always_ff @(posedge clk) begin
		if (rst) begin
			wdt_en <= 1'b0;
			timeout <= `CSR_DATA_W'(`WDT_DEFAULT_TIMEOUT);
			count <= `CSR_DATA_W'(`WDT_DEFAULT_TIMEOUT);
			wdt_time_out <= 1'b0;
			wdt_evt <= 1'b0;
		end else begin
			wdt_evt <= 1'b0;
			if (wr_timeout)
				timeout <= csr_req.wdata;
			if (wr_ctrl) begin
				wdt_en <= csr_req.wdata[0];
				wdt_time_out <= 1'b0;  // any control write clears the flag.
				count <= timeout;
			end else if (wr_kick || !pwr_enable) begin
				count <= timeout;  // fresh start at power on.
			end else if (wdt_en && !wdt_time_out && ce_tick) begin
				if (count <= `CSR_DATA_W'(1)) begin
					count <= '0;
					wdt_time_out <= 1'b1;
					wdt_evt <= 1'b1;
				end else begin
					count <= count - 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rst)
			csr_rdata <= '0;
		else if (!csr_req.we && csr_req.addr == WDT_CTRL)
			csr_rdata <= {{(`CSR_DATA_W - 2){1'b0}}, wdt_time_out, wdt_en};
		else if (!csr_req.we && csr_req.addr == WDT_TIMEOUT)
			csr_rdata <= timeout;
		else
			csr_rdata <= '0;
	end

endmodule

//--- logic/gpio_bank.sv
`include "board_ctrl_cfg.svh"

module gpio_bank import board_ctrl_pkg::*; #(
	parameter int NUM_GPIOS = `GPIO_COUNT
) (
	input  logic clk,
	input  logic rst,
	input  logic pwr_enable,
	input  csr_req_t csr_req,
	input  logic [NUM_GPIOS-1:0] gpio_in,
	output logic [`CSR_DATA_W-1:0] csr_rdata,
	output logic [NUM_GPIOS-1:0] gpio_out,
	output logic [NUM_GPIOS-1:0] gpio_oe,
	output logic gpio_evt
);

	logic [NUM_GPIOS-1:0] out_r;
	logic [NUM_GPIOS-1:0] oe_r;
	logic [NUM_GPIOS-1:0] irq_en;
	logic [NUM_GPIOS-1:0] in_meta;
	logic [NUM_GPIOS-1:0] in_sync;
	logic [NUM_GPIOS-1:0] in_prev;
	logic [NUM_GPIOS-1:0] changed;

	assign changed = (in_sync ^ in_prev) & irq_en;
	assign gpio_out = out_r;
	assign gpio_oe = oe_r & {NUM_GPIOS{pwr_enable}};  // float while off.

	always_ff @(posedge clk) begin
		in_meta <= gpio_in;
		in_sync <= in_meta;
		in_prev <= in_sync;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			out_r <= '0;
			oe_r <= '0;
			irq_en <= '0;
			gpio_evt <= 1'b0;
		end else begin
			if (csr_req.we && csr_req.addr == GPIO_OUT)
				out_r <= csr_req.wdata[NUM_GPIOS-1:0];
			if (csr_req.we && csr_req.addr == GPIO_OE)
				oe_r <= csr_req.wdata[NUM_GPIOS-1:0];
			if (csr_req.we && csr_req.addr == GPIO_IRQ_EN)
				irq_en <= csr_req.wdata[NUM_GPIOS-1:0];
			gpio_evt <= |changed;  // any enabled pin toggled.
		end
	end

	always_ff @(posedge clk) begin
		if (rst || csr_req.we) begin
			csr_rdata <= '0;
		end else begin
			case (csr_req.addr)
			GPIO_OUT: csr_rdata <= `CSR_DATA_W'(out_r);
			GPIO_OE: csr_rdata <= `CSR_DATA_W'(oe_r);
			GPIO_IN: csr_rdata <= `CSR_DATA_W'(in_sync);
			GPIO_IRQ_EN: csr_rdata <= `CSR_DATA_W'(irq_en);
			default: csr_rdata <= '0;
			endcase
		end
	end

endmodule

//--- logic/irq_ctrl.sv
`include "board_ctrl_cfg.svh"

module irq_ctrl import board_ctrl_pkg::*; (
	input  logic clk,
	input  logic rst,
	input  csr_req_t csr_req,
	input  irq_src_t irq_src,
	output logic [`CSR_DATA_W-1:0] csr_rdata,
	output logic irq
);

	localparam int NUM_IRQS = $bits(irq_src_t);

	logic [NUM_IRQS-1:0] pending;
	logic [NUM_IRQS-1:0] enable;
	logic [NUM_IRQS-1:0] clr;

	// write one to clear.
	assign clr = (csr_req.we && csr_req.addr == IRQ_PENDING) ?
		csr_req.wdata[NUM_IRQS-1:0] : '0;

	// ****************************************
	// pending and enable
	// ****************************************

	always_ff @(posedge clk) begin
		if (rst) begin
			pending <= '0;
			enable <= '0;
			irq <= 1'b0;
		end else begin
			pending <= (pending & ~clr) | irq_src;  // new event wins over clear.
			if (csr_req.we && csr_req.addr == IRQ_ENABLE)
				enable <= csr_req.wdata[NUM_IRQS-1:0];
			irq <= |(pending & enable);
		end
	end

	always_ff @(posedge clk) begin
		if (rst)
			csr_rdata <= '0;
		else if (!csr_req.we && csr_req.addr == IRQ_PENDING)
			csr_rdata <= `CSR_DATA_W'(pending);
		else if (!csr_req.we && csr_req.addr == IRQ_ENABLE)
			csr_rdata <= `CSR_DATA_W'(enable);
		else
			csr_rdata <= '0;
	end

endmodule

//--- logic/board_ctrl_top.sv
`include "board_ctrl_cfg.svh"

module board_ctrl_top import board_ctrl_pkg::*; (
	input  logic clk,
	input  logic rst,
	input  csr_req_t csr_req,
	input  logic pwr_btn_n,
	input  logic wake_n,
	input  logic [`GPIO_COUNT-1:0] gpio_in,
	output logic [`CSR_DATA_W-1:0] csr_rdata,
	output logic pwr_enable,
	output logic wdt_time_out,
	output logic [`GPIO_COUNT-1:0] gpio_out,
	output logic [`GPIO_COUNT-1:0] gpio_oe,
	output logic irq
);

	logic ce_tick;
	logic pwr_btn_evt;
	logic wake_evt;
	logic wdt_evt;
	logic gpio_evt;
	irq_src_t irq_src;
	logic [`CSR_DATA_W-1:0] rdata_pwr;
	logic [`CSR_DATA_W-1:0] rdata_wdt;
	logic [`CSR_DATA_W-1:0] rdata_gpio;
	logic [`CSR_DATA_W-1:0] rdata_irq;

	assign irq_src = '{wdt: wdt_evt, gpio: gpio_evt, pwr_btn: pwr_btn_evt, wake: wake_evt};
	assign csr_rdata = rdata_pwr | rdata_wdt | rdata_gpio | rdata_irq;  // idle blocks read 0.

	tick_gen i_tick_gen (.clk(clk), .rst(rst), .ce_tick(ce_tick));

	power_seq i_power_seq (
		.clk(clk), .rst(rst), .ce_tick(ce_tick),
		.pwr_btn_n(pwr_btn_n), .wake_n(wake_n),
		.csr_req(csr_req), .csr_rdata(rdata_pwr),
		.pwr_enable(pwr_enable), .pwr_btn_evt(pwr_btn_evt), .wake_evt(wake_evt)
	);

	watchdog i_watchdog (
		.clk(clk), .rst(rst), .ce_tick(ce_tick), .pwr_enable(pwr_enable),
		.csr_req(csr_req), .csr_rdata(rdata_wdt),
		.wdt_time_out(wdt_time_out), .wdt_evt(wdt_evt)
	);

	gpio_bank #(
		.NUM_GPIOS(`GPIO_COUNT)
	) i_gpio_bank (
		.clk(clk), .rst(rst), .pwr_enable(pwr_enable),
		.csr_req(csr_req), .gpio_in(gpio_in), .csr_rdata(rdata_gpio),
		.gpio_out(gpio_out), .gpio_oe(gpio_oe), .gpio_evt(gpio_evt)
	);

	irq_ctrl i_irq_ctrl (
		.clk(clk), .rst(rst), .csr_req(csr_req), .irq_src(irq_src),
		.csr_rdata(rdata_irq), .irq(irq)
	);

endmodule

//--- tests/board_ctrl_asserts.sv
`include "board_ctrl_cfg.svh"

module board_ctrl_asserts import board_ctrl_pkg::*; (
	input  logic clk,
	input  logic rst,
	input  csr_req_t csr_req,
	input  logic [`CSR_DATA_W-1:0] csr_rdata,
	input  logic pwr_enable,
	input  logic wdt_time_out,
	input  logic [`GPIO_COUNT-1:0] gpio_oe,
	input  logic irq
);

	// outputs come out of reset inactive.
	reset_idle: assert property (@(posedge clk)
		rst |=> !pwr_enable && !irq && !wdt_time_out)
		else $error("pwr_enable, irq or wdt_time_out active after reset");

	oe_floats_off: assert property (@(posedge clk) disable iff (rst)
		!pwr_enable |-> gpio_oe == '0)
		else $error("gpio_oe driven while power is off");

	write_reads_zero: assert property (@(posedge clk) disable iff (rst)
		csr_req.we |=> csr_rdata == '0)  // no block answers a write.
		else $error("csr_rdata not zero after a write");

endmodule

bind board_ctrl_top board_ctrl_asserts i_board_ctrl_asserts (.*);

//--- tests/board_ctrl_tb.sv
`include "board_ctrl_cfg.svh"

module board_ctrl_tb import board_ctrl_pkg::*; ();

	localparam int TIMEOUT_CYCLES = 3000;
	localparam logic [`CSR_DATA_W-1:0] WDT_T = 8'd5;

	logic clk;
	logic rst;
	csr_req_t csr_req;
	logic pwr_btn_n;
	logic wake_n;
	logic [`GPIO_COUNT-1:0] gpio_in;
	logic [`CSR_DATA_W-1:0] csr_rdata;
	logic pwr_enable;
	logic wdt_time_out;
	logic [`GPIO_COUNT-1:0] gpio_out;
	logic [`GPIO_COUNT-1:0] gpio_oe;
	logic irq;
	int errors;
	int checks;
	int cycles;

	board_ctrl_top i_board_ctrl_top (
		.clk(clk), .rst(rst), .csr_req(csr_req),
		.pwr_btn_n(pwr_btn_n), .wake_n(wake_n), .gpio_in(gpio_in),
		.csr_rdata(csr_rdata), .pwr_enable(pwr_enable), .wdt_time_out(wdt_time_out),
		.gpio_out(gpio_out), .gpio_oe(gpio_oe), .irq(irq)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// ****************************************
	// bus and compare tasks
	// ****************************************

	task automatic next_cycle();
		@(posedge clk);
		#2;  // inputs change just after the edge.
	endtask

	task automatic wait_cycles(input int n);
		repeat (n) next_cycle();
	endtask

	task automatic bus_write(input csr_addr_e reg_addr, input logic [`CSR_DATA_W-1:0] value);
		csr_req.addr = reg_addr;
		csr_req.we = 1'b1;
		csr_req.wdata = value;
		next_cycle();
		csr_req = '0;
	endtask

	// data is registered at the edge that takes the request.
	task automatic bus_read(input csr_addr_e reg_addr, output logic [`CSR_DATA_W-1:0] data);
		csr_req.addr = reg_addr;
		csr_req.we = 1'b0;
		csr_req.wdata = '0;
		next_cycle();
		csr_req = '0;
		data = csr_rdata;
	endtask

	task automatic read_pending(output irq_src_t pend);
		logic [`CSR_DATA_W-1:0] rd;
		bus_read(IRQ_PENDING, rd);
		pend = rd[$bits(irq_src_t)-1:0];
	endtask

	function automatic irq_src_t pending_of(input logic wdt, gpio, pwr_btn, wake);
		irq_src_t p;
		p.wdt = wdt;
		p.gpio = gpio;
		p.pwr_btn = pwr_btn;
		p.wake = wake;
		return p;
	endfunction

	task automatic check_data(input string name, input logic [`CSR_DATA_W-1:0] exp, act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("Fail %s: expected %h, actual %h", name, exp, act);
		end
	endtask

	task automatic check_bit(input string name, input logic exp, act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("Fail %s: expected %b, actual %b", name, exp, act);
		end
	endtask

	task automatic check_irq(input string name, input irq_src_t exp, act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("Fail %s: expected %b, actual %b", name, exp, act);
		end
	endtask

	task automatic power_on_by_wake(input string name);
		int n;
		wake_n = 1'b0;
		n = 0;
		while (pwr_enable !== 1'b1 && n < 4) begin
			next_cycle();
			n++;
		end
		check_bit(name, 1'b1, pwr_enable);
		wake_n = 1'b1;
		wait_cycles(3);
	endtask

	// ****************************************
	// directed tests
	// ****************************************

	task automatic test_reset_power_on();
		int n;
		logic [`CSR_DATA_W-1:0] rd;
		check_bit("reset_pwr_enable", 1'b0, pwr_enable);
		check_bit("reset_irq", 1'b0, irq);
		check_bit("reset_wdt_time_out", 1'b0, wdt_time_out);
		check_data("reset_gpio_oe", '0, gpio_oe);
		pwr_btn_n = 1'b0;
		n = 0;
		while (pwr_enable !== 1'b1 && n < 4) begin
			next_cycle();
			n++;
		end
		check_bit("button_power_on", 1'b1, pwr_enable);
		pwr_btn_n = 1'b1;  // short press.
		wait_cycles(4);
		bus_read(PWR_CTRL, rd);
		check_data("pwr_ctrl_on", 8'h01, rd);
	endtask

	task automatic test_long_press();
		int n;
		pwr_btn_n = 1'b0;
		n = 0;
		while (pwr_enable !== 1'b0 && n < (`LONG_PRESS_TICKS + 1) * `CE_TICK_DIV) begin
			next_cycle();
			n++;
		end
		check_bit("long_press_off", 1'b0, pwr_enable);
		check_bit("long_press_not_early", 1'b1, n > (`LONG_PRESS_TICKS - 1) * `CE_TICK_DIV);
		wait_cycles(2 * `CE_TICK_DIV);
		check_bit("held_stays_off", 1'b0, pwr_enable);
		pwr_btn_n = 1'b1;
		wait_cycles(4);
		check_bit("release_stays_off", 1'b0, pwr_enable);
		power_on_by_wake("wake_power_on");
		bus_write(PWR_CTRL, 8'h01);
		check_bit("reg_power_off", 1'b0, pwr_enable);
	endtask

	task automatic test_gpio();
		int n;
		logic [`CSR_DATA_W-1:0] rd;
		irq_src_t pend;
		bus_write(GPIO_OE, 8'h3c);
		check_data("oe_while_off", '0, gpio_oe);
		bus_read(GPIO_OE, rd);
		check_data("oe_readback", 8'h3c, rd);
		power_on_by_wake("gpio_power_on");
		check_data("oe_while_on", 8'h3c, gpio_oe);
		bus_write(GPIO_OUT, 8'ha5);
		check_data("out_port", 8'ha5, gpio_out);
		bus_read(GPIO_OUT, rd);
		check_data("out_readback", 8'ha5, rd);
		bus_write(GPIO_IRQ_EN, 8'h01);
		bus_write(IRQ_PENDING, 8'h0f);
		gpio_in[7] = 1'b1;  // masked pin.
		wait_cycles(6);
		read_pending(pend);
		check_irq("gpio_masked", pending_of(1'b0, 1'b0, 1'b0, 1'b0), pend);
		gpio_in[0] = 1'b1;
		n = 0;
		while (!pend.gpio && n < 6) begin
			read_pending(pend);
			n++;
		end
		check_irq("gpio_pending", pending_of(1'b0, 1'b1, 1'b0, 1'b0), pend);
		bus_read(GPIO_IN, rd);
		check_data("in_readback", 8'h81, rd);
	endtask

	task automatic test_watchdog();
		int n;
		logic [`CSR_DATA_W-1:0] rd;
		irq_src_t pend;
		bus_write(WDT_TIMEOUT, WDT_T);
		bus_read(WDT_TIMEOUT, rd);
		check_data("wdt_timeout_readback", WDT_T, rd);
		bus_write(IRQ_PENDING, 8'h0f);
		bus_write(WDT_CTRL, 8'h01);
		wait_cycles((WDT_T - 1) * `CE_TICK_DIV);
		check_bit("wdt_not_yet", 1'b0, wdt_time_out);
		bus_write(WDT_KICK, 8'h00);
		wait_cycles((WDT_T - 1) * `CE_TICK_DIV);
		check_bit("wdt_kicked", 1'b0, wdt_time_out);
		n = 0;
		while (wdt_time_out !== 1'b1 && n < 2 * `CE_TICK_DIV) begin
			next_cycle();
			n++;
		end
		check_bit("wdt_expired", 1'b1, wdt_time_out);
		bus_read(WDT_CTRL, rd);
		check_data("wdt_ctrl_flag", 8'h03, rd);
		read_pending(pend);
		check_irq("wdt_pending", pending_of(1'b1, 1'b0, 1'b0, 1'b0), pend);
		bus_write(WDT_CTRL, 8'h00);
		check_bit("wdt_flag_cleared", 1'b0, wdt_time_out);
	endtask

	task automatic test_irq();
		int n;
		irq_src_t pend;
		bus_write(IRQ_ENABLE, `CSR_DATA_W'(pending_of(1'b0, 1'b1, 1'b0, 1'b0)));
		wait_cycles(2);
		check_bit("irq_masked", 1'b0, irq);
		bus_write(IRQ_ENABLE, `CSR_DATA_W'(pending_of(1'b1, 1'b0, 1'b0, 1'b0)));
		n = 0;
		while (irq !== 1'b1 && n < 2) begin
			next_cycle();
			n++;
		end
		check_bit("irq_enabled", 1'b1, irq);
		bus_write(IRQ_PENDING, `CSR_DATA_W'(pending_of(1'b1, 1'b0, 1'b0, 1'b0)));
		n = 0;
		while (irq !== 1'b0 && n < 2) begin
			next_cycle();
			n++;
		end
		check_bit("irq_cleared", 1'b0, irq);
		read_pending(pend);
		check_irq("pending_cleared", pending_of(1'b0, 1'b0, 1'b0, 1'b0), pend);
		pwr_btn_n = 1'b0;
		wait_cycles(4);
		pwr_btn_n = 1'b1;
		wait_cycles(4);
		check_bit("short_press_stays_on", 1'b1, pwr_enable);
		read_pending(pend);
		check_irq("button_event", pending_of(1'b0, 1'b0, 1'b1, 1'b0), pend);
		bus_write(IRQ_PENDING, 8'h0f);
		bus_write(PWR_CTRL, 8'h01);
		power_on_by_wake("irq_wake_on");
		read_pending(pend);
		check_irq("wake_event", pending_of(1'b0, 1'b0, 1'b0, 1'b1), pend);
	endtask

	// ****************************************
	// run control
	// ****************************************

	initial begin
		rst = 1'b1;
		csr_req = '0;
		pwr_btn_n = 1'b1;
		wake_n = 1'b1;
		gpio_in = '0;
		errors = 0;
		checks = 0;
		wait_cycles(8);
		rst = 1'b0;
		test_reset_power_on();
		test_long_press();
		test_gpio();
		test_watchdog();
		test_irq();
		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("Test OK");
		else
			$display("Test FAILED");
		$finish;
	end

	initial begin
		cycles = 0;
		while (cycles < TIMEOUT_CYCLES) begin
			@(posedge clk);
			cycles++;
		end
		$display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
		$display("Test FAILED");
		$finish;
	end

endmodule

//--- compile.f
+incdir+logic
logic/board_ctrl_pkg.sv
logic/tick_gen.sv
logic/power_seq.sv
logic/watchdog.sv
logic/gpio_bank.sv
logic/irq_ctrl.sv
logic/board_ctrl_top.sv
tests/board_ctrl_asserts.sv
tests/board_ctrl_tb.sv
